// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int index_width = 4
) (
    input  logic                                          clk,
    input  logic                                          rstn,
    // pipeline side
    input  logic                                          valid,
    output logic                                          ready,
    input  logic                                          op,
    input  logic [1:0]                                    op_code,
    input  logic                                          wr,
    input  logic                                          uncached,
    input  logic [dcache_pkg::addr_width-1:0]             addr,
    input  logic [dcache_pkg::data_width-1:0]             wdata,
    input  logic [dcache_pkg::data_width/8-1:0]           wstrb,
    output logic                                          op_ack,
    output logic                                          rdata_valid,
    output logic                                          return_sel,
    // ways and replacement
    input  logic                                          hit0,
    input  logic                                          hit1,
    input  logic                                          victim,
    output logic [index_width-1:0]                        index,
    output logic [dcache_pkg::addr_width-index_width-3:0] tag,
    output logic [dcache_pkg::data_width-1:0]             way_wdata,
    output logic [dcache_pkg::data_width/8-1:0]           way_wstrb,
    output logic                                          we0,
    output logic                                          we1,
    output logic                                          fill,
    output logic                                          invalidate0,
    output logic                                          invalidate1,
    output logic                                          use_en,
    output logic                                          use_way,
    // memory bus
    output logic                                          mem_req,
    output logic                                          mem_wr,
    output logic [dcache_pkg::addr_width-1:0]             mem_addr,
    output logic [dcache_pkg::data_width-1:0]             mem_wdata,
    output logic [dcache_pkg::data_width/8-1:0]           mem_wstrb,
    input  logic                                          mem_addr_ok,
    input  logic                                          mem_data_ok
);

    dcache_pkg::ctrl_state_t state_q;
    dcache_pkg::ctrl_state_t state_d;

    logic                                buf_wr;
    logic                                buf_uncached;
    logic [1:0]                          buf_op_code;
    logic [dcache_pkg::addr_width-1:0]   buf_addr;
    logic [dcache_pkg::data_width-1:0]   buf_wdata;
    logic [dcache_pkg::data_width/8-1:0] buf_wstrb;

    logic miss;
    logic accept;

    //////////////////////////////////////////////////////////////////////
    // request buffer
    //////////////////////////////////////////////////////////////////////
    assign accept = valid && ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_wr       <= 1'b0;
            buf_uncached <= 1'b0;
        end else if (accept) begin
            buf_wr       <= wr;
            buf_uncached <= uncached;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_op_code <= op_code;
            buf_addr    <= addr;
            buf_wdata   <= wdata;
            buf_wstrb   <= wstrb;
        end
    end

    assign index     = buf_addr[index_width+1:2];
    assign tag       = buf_addr[dcache_pkg::addr_width-1:index_width+2];
    assign way_wdata = buf_wdata;
    assign mem_addr  = buf_addr;
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wr ? buf_wstrb : '0;

    // strongly ordered never counts as a hit
    assign miss = !(hit0 || hit1) || buf_uncached;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= dcache_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        ready       = 1'b0;
        op_ack      = 1'b0;
        rdata_valid = 1'b0;
        return_sel  = 1'b0;
        way_wstrb   = buf_wstrb;
        we0         = 1'b0;
        we1         = 1'b0;
        fill        = 1'b0;
        invalidate0 = 1'b0;
        invalidate1 = 1'b0;
        use_en      = 1'b0;
        use_way     = 1'b0;
        mem_req     = 1'b0;
        mem_wr      = 1'b0;
        case (state_q)
            dcache_pkg::st_idle: begin
                ready = 1'b1;
            end
            dcache_pkg::st_lookup: begin
                if (buf_uncached) begin // drop any stale copy
                    invalidate0 = hit0;
                    invalidate1 = hit1;
                end
                mem_req = buf_wr || miss;
                mem_wr  = buf_wr;
                if (!miss) begin
                    use_en  = 1'b1;
                    use_way = !hit0;
                    if (buf_wr) begin // merge into the hitting line
                        we0 = hit0;
                        we1 = !hit0;
                    end else begin
                        rdata_valid = 1'b1;
                    end
                end
                ready = buf_wr ? mem_addr_ok : !miss;
            end
            dcache_pkg::st_miss_wait: begin
                mem_req = 1'b1;
            end
            dcache_pkg::st_wr_wait: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                ready   = mem_addr_ok;
            end
            dcache_pkg::st_refill: begin
                ready       = 1'b1;
                rdata_valid = 1'b1;
                return_sel  = 1'b1;
                way_wstrb   = '1; // whole word
                if (!buf_uncached) begin
                    fill    = 1'b1;
                    we0     = !victim;
                    we1     = victim;
                    use_en  = 1'b1;
                    use_way = victim;
                end
            end
            dcache_pkg::st_operation: begin
                ready  = 1'b1;
                op_ack = 1'b1;
                case (buf_op_code)
                    dcache_pkg::op_index_inv: begin
                        invalidate0 = !buf_addr[0]; // way from address bit 0
                        invalidate1 = buf_addr[0];
                    end
                    dcache_pkg::op_hit_inv: begin
                        invalidate0 = hit0;
                        invalidate1 = hit1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::st_lookup: begin
                if (buf_wr) begin
                    state_d = mem_addr_ok ? dcache_pkg::st_idle : dcache_pkg::st_wr_wait;
                end else if (miss) begin
                    state_d = mem_data_ok ? dcache_pkg::st_refill : dcache_pkg::st_miss_wait;
                end else begin
                    state_d = dcache_pkg::st_idle;
                end
            end
            dcache_pkg::st_miss_wait: begin
                if (mem_data_ok) begin
                    state_d = dcache_pkg::st_refill;
                end
            end
            dcache_pkg::st_wr_wait: begin
                if (mem_addr_ok) begin
                    state_d = dcache_pkg::st_idle;
                end
            end
            default: state_d = dcache_pkg::st_idle;
        endcase
        // new request wherever ready is high
        if (accept) begin
            state_d = op ? dcache_pkg::st_operation : dcache_pkg::st_lookup;
        end
    end

endmodule

// ==== dcache_lru.sv ====
`timescale 1ns/1ps

module dcache_lru #(
    parameter int index_width = 4
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   use_en,
    input  logic                   use_way,
    output logic                   victim
);

    localparam int sets = 1 << index_width;

    logic [sets-1:0] lru_q; // names the least recently used way

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use_en) begin
            lru_q[index] <= ~use_way; // other way is now older
        end
    end

    assign victim = lru_q[index];

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int data_width = 32;
    localparam int addr_width = 32;

    // cache operation codes
    localparam logic [1:0] op_index_inv = 2'd0;
    localparam logic [1:0] op_hit_inv   = 2'd1;

    //////////////////////////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_lookup    = 3'd1,
        st_miss_wait = 3'd2, // read out on the bus
        st_refill    = 3'd3,
        st_wr_wait   = 3'd4, // write waiting for addr_ok
        st_operation = 3'd5
    } ctrl_state_t;

endpackage

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter int index_width = 4
) (
    input  logic                                clk,
    input  logic                                rstn,
    // pipeline side
    input  logic                                valid,
    output logic                                ready,
    input  logic                                op,
    input  logic [1:0]                          op_code,
    input  logic                                wr,
    input  logic                                uncached,
    input  logic [dcache_pkg::addr_width-1:0]   addr,
    input  logic [dcache_pkg::data_width-1:0]   wdata,
    input  logic [dcache_pkg::data_width/8-1:0] wstrb,
    output logic [dcache_pkg::data_width-1:0]   rdata,
    output logic                                rdata_valid,
    output logic                                op_ack,
    // memory bus
    output logic                                mem_req,
    output logic                                mem_wr,
    output logic [dcache_pkg::addr_width-1:0]   mem_addr,
    output logic [dcache_pkg::data_width-1:0]   mem_wdata,
    output logic [dcache_pkg::data_width/8-1:0] mem_wstrb,
    input  logic                                mem_addr_ok,
    input  logic                                mem_data_ok,
    input  logic [dcache_pkg::data_width-1:0]   mem_rdata
);

    logic [index_width-1:0]                        index;
    logic [dcache_pkg::addr_width-index_width-3:0] tag;
    logic [dcache_pkg::data_width-1:0]             way_wdata;
    logic [dcache_pkg::data_width-1:0]             fill_wdata;
    logic [dcache_pkg::data_width/8-1:0]           way_wstrb;
    logic [dcache_pkg::data_width-1:0]             way0_rdata;
    logic [dcache_pkg::data_width-1:0]             way1_rdata;
    logic [dcache_pkg::data_width-1:0]             refill_q;
    logic hit0;
    logic hit1;
    logic we0;
    logic we1;
    logic fill;
    logic invalidate0;
    logic invalidate1;
    logic use_en;
    logic use_way;
    logic victim;
    logic return_sel;

    // memory word held for the refill cycle
    always_ff @(posedge clk) begin
        if (mem_data_ok) begin
            refill_q <= mem_rdata;
        end
    end

    assign fill_wdata = return_sel ? refill_q : way_wdata;
    assign rdata      = return_sel ? refill_q : (hit0 ? way0_rdata : way1_rdata);

    //////////////////////////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////////////////////////
    dcache_way #(.index_width(index_width)) i_way0 (
        .clk        (clk),
        .rstn       (rstn),
        .index      (index),
        .tag        (tag),
        .wdata      (fill_wdata),
        .wstrb      (way_wstrb),
        .we         (we0),
        .fill       (fill),
        .invalidate (invalidate0),
        .hit        (hit0),
        .way_rdata  (way0_rdata)
    );

    dcache_way #(.index_width(index_width)) i_way1 (
        .clk        (clk),
        .rstn       (rstn),
        .index      (index),
        .tag        (tag),
        .wdata      (fill_wdata),
        .wstrb      (way_wstrb),
        .we         (we1),
        .fill       (fill),
        .invalidate (invalidate1),
        .hit        (hit1),
        .way_rdata  (way1_rdata)
    );

    dcache_lru #(.index_width(index_width)) i_lru (
        .clk     (clk),
        .rstn    (rstn),
        .index   (index),
        .use_en  (use_en),
        .use_way (use_way),
        .victim  (victim)
    );

    dcache_ctrl #(.index_width(index_width)) i_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .ready       (ready),
        .op          (op),
        .op_code     (op_code),
        .wr          (wr),
        .uncached    (uncached),
        .addr        (addr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .op_ack      (op_ack),
        .rdata_valid (rdata_valid),
        .return_sel  (return_sel),
        .hit0        (hit0),
        .hit1        (hit1),
        .victim      (victim),
        .index       (index),
        .tag         (tag),
        .way_wdata   (way_wdata),
        .way_wstrb   (way_wstrb),
        .we0         (we0),
        .we1         (we1),
        .fill        (fill),
        .invalidate0 (invalidate0),
        .invalidate1 (invalidate1),
        .use_en      (use_en),
        .use_way     (use_way),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok)
    );

endmodule

// ==== dcache_way.sv ====
`timescale 1ns/1ps

module dcache_way #(
    parameter int index_width = 4
) (
    input  logic                                         clk,
    input  logic                                         rstn,
    input  logic [index_width-1:0]                       index,
    input  logic [dcache_pkg::addr_width-index_width-3:0] tag,
    input  logic [dcache_pkg::data_width-1:0]            wdata,
    input  logic [dcache_pkg::data_width/8-1:0]          wstrb,
    input  logic                                         we,
    input  logic                                         fill,
    input  logic                                         invalidate,
    output logic                                         hit,
    output logic [dcache_pkg::data_width-1:0]            way_rdata
);

    localparam int sets      = 1 << index_width;
    localparam int tag_width = dcache_pkg::addr_width - index_width - 2;
    localparam int nbytes    = dcache_pkg::data_width / 8;

    logic [sets-1:0]                 valid_q;
    logic [tag_width-1:0]            tag_q  [sets];
    logic [dcache_pkg::data_width-1:0] data_q [sets];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (invalidate) begin
            valid_q[index] <= 1'b0;
        end else if (we && fill) begin
            valid_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we && fill) begin
            tag_q[index] <= tag;
        end
    end

    // byte lanes under strobe
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < nbytes; b++) begin
                if (wstrb[b]) begin
                    data_q[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign way_rdata = data_q[index];
    assign hit       = valid_q[index] && (tag_q[index] == tag);

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_dcache -f verilog.f &&
./obj_dir/Vtb_dcache | tee /dev/stderr | grep -q "All tests passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int period       = 40,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk); // release between edges
        rstn = 1'b1;
    end

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

    localparam int index_width = 4;
    localparam int sets        = 1 << index_width;
    localparam int n_requests  = 24;

    logic        clk;
    logic        rstn;
    logic        valid;
    logic        ready;
    logic        op;
    logic [1:0]  op_code;
    logic        wr;
    logic        uncached;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        op_ack;
    logic        mem_req;
    logic        mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_addr_ok;
    logic        mem_data_ok;
    logic [31:0] mem_rdata;
    logic        poke_en;
    logic [31:0] poke_addr;
    logic [31:0] poke_data;

    // reference model of memory, tags, valids and replacement bits
    logic [31:0] exp_mem [1024];
    logic        m_valid [2][sets];
    logic [31:0] m_tag   [2][sets];
    logic [31:0] m_data  [2][sets];
    logic        m_lru   [sets];

    tb_clock #(.period(40), .reset_cycles(8)) i_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    dcache_top #(.index_width(index_width)) i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .ready       (ready),
        .op          (op),
        .op_code     (op_code),
        .wr          (wr),
        .uncached    (uncached),
        .addr        (addr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .op_ack      (op_ack),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    tb_mem i_mem (
        .clk         (clk),
        .rstn        (rstn),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata),
        .poke_en     (poke_en),
        .poke_addr   (poke_addr),
        .poke_data   (poke_data)
    );

    task automatic fail_run(input string msg);
        $display("Error: %0t ns: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus rules
    //////////////////////////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_addr_ok && !mem_data_ok) |=> (mem_req && mem_wr == $past(mem_wr)
            && mem_addr == $past(mem_addr) && mem_wdata == $past(mem_wdata)
            && mem_wstrb == $past(mem_wstrb)))
        else fail_run("memory request changed before memory answered it");

    assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_addr_ok && !mem_data_ok) |-> !ready)
        else fail_run("ready high while memory is still pending");

    assert property (@(posedge clk) disable iff (!rstn) !(rdata_valid && op_ack))
        else fail_run("rdata_valid and op_ack high in the same cycle");

    function automatic int set_of(input logic [31:0] a);
        return int'(a[index_width+1:2]);
    endfunction

    function automatic logic [31:0] tag_of(input logic [31:0] a);
        return a >> (index_width + 2);
    endfunction

    function automatic logic [31:0] line_addr(input int t, input int s);
        return (32'(t) << (index_width + 2)) | (32'(s) << 2);
    endfunction

    function automatic int hit_way(input logic [31:0] a);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][set_of(a)] && m_tag[w][set_of(a)] == tag_of(a)) begin
                return w;
            end
        end
        return -1; // miss
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                                input logic [3:0] s);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = d[8*b +: 8];
            end
        end
        return r;
    endfunction

    // called at a falling edge and returns in the cycle after acceptance
    task automatic issue_request(input logic is_op, input logic [1:0] code, input logic is_wr,
                                 input logic is_unc, input logic [31:0] a,
                                 input logic [31:0] d, input logic [3:0] s);
        valid    = 1'b1;
        op       = is_op;
        op_code  = code;
        wr       = is_wr;
        uncached = is_unc;
        addr     = a;
        wdata    = d;
        wstrb    = s;
        while (!ready) @(negedge clk);
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] a, input logic unc);
        int          st;
        int          way;
        int          v;
        int          rd_before;
        logic        hit;
        logic [31:0] expected;
        st        = set_of(a);
        way       = hit_way(a);
        hit       = (way >= 0) && !unc;
        rd_before = i_mem.rd_count;
        issue_request(1'b0, 2'd0, 1'b0, unc, a, 32'd0, 4'd0);
        if (hit) begin
            expected  = m_data[way][st];
            m_lru[st] = (way == 0);
            assert (rdata_valid)
                else fail_run($sformatf("read hit of %08h gave no data after acceptance", a));
        end else begin
            expected = exp_mem[a[11:2]];
            if (unc && way >= 0) begin
                m_valid[way][st] = 1'b0; // stale copy dropped
            end else if (!unc) begin
                v            = m_lru[st] ? 1 : 0;
                m_valid[v][st] = 1'b1;
                m_tag[v][st]   = tag_of(a);
                m_data[v][st]  = expected;
                m_lru[st]      = (v == 0);
            end
            while (!rdata_valid) @(negedge clk);
        end
        assert (rdata == expected)
            else fail_run($sformatf("read of %08h returned %08h, expected %08h",
                                    a, rdata, expected));
        assert (i_mem.rd_count == rd_before + (hit ? 0 : 1))
            else fail_run($sformatf("read of %08h made %0d memory reads, expected %0d",
                                    a, i_mem.rd_count - rd_before, hit ? 0 : 1));
    endtask

    task automatic write_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        int st;
        int way;
        int rd_before;
        int wr_before;
        st        = set_of(a);
        way       = hit_way(a);
        rd_before = i_mem.rd_count;
        wr_before = i_mem.wr_count;
        exp_mem[a[11:2]] = merge_bytes(exp_mem[a[11:2]], d, s);
        if (way >= 0) begin // no allocate on a miss
            m_data[way][st] = merge_bytes(m_data[way][st], d, s);
            m_lru[st]       = (way == 0);
        end
        issue_request(1'b0, 2'd0, 1'b1, 1'b0, a, d, s);
        while (!ready) @(negedge clk);
        @(negedge clk);
        assert (i_mem.wr_count == wr_before + 1 && i_mem.rd_count == rd_before)
            else fail_run($sformatf("write to %08h made %0d writes and %0d reads",
                                    a, i_mem.wr_count - wr_before, i_mem.rd_count - rd_before));
        assert (i_mem.last_addr == a && i_mem.last_wdata == d && i_mem.last_wstrb == s)
            else fail_run($sformatf("memory write %08h/%08h/%h, expected %08h/%08h/%h",
                                    i_mem.last_addr, i_mem.last_wdata, i_mem.last_wstrb,
                                    a, d, s));
    endtask

    task automatic run_cache_op(input logic [1:0] code, input logic [31:0] a);
        int way;
        way = hit_way(a);
        if (code == dcache_pkg::op_index_inv) begin
            m_valid[a[0]][set_of(a)] = 1'b0; // way from address bit 0
        end else if (way >= 0) begin
            m_valid[way][set_of(a)] = 1'b0;
        end
        issue_request(1'b1, code, 1'b0, 1'b0, a, 32'd0, 4'd0);
        assert (op_ack && ready)
            else fail_run($sformatf("operation %0d at %08h not acknowledged", code, a));
        @(negedge clk);
        assert (!op_ack) else fail_run("op_ack held for more than one cycle");
    endtask

    task automatic change_memory(input logic [31:0] a, input logic [31:0] d);
        exp_mem[a[11:2]] = d;
        poke_en   = 1'b1;
        poke_addr = a;
        poke_data = d;
        @(negedge clk);
        poke_en = 1'b0;
    endtask

    initial begin
        dcache_pkg::ctrl_state_t stuck;
        repeat (8 + n_requests * 10 + 50) @(posedge clk);
        stuck = i_dut.i_ctrl.state_q;
        $display("Timeout: the run did not finish in time, controller in state %s",
                 stuck.name());
        $display("Some tests failed");
        $fatal(1);
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        valid     = 1'b0;
        op        = 1'b0;
        op_code   = 2'd0;
        wr        = 1'b0;
        uncached  = 1'b0;
        addr      = '0;
        wdata     = '0;
        wstrb     = '0;
        poke_en   = 1'b0;
        poke_addr = '0;
        poke_data = '0;
        for (int st = 0; st < sets; st++) begin
            m_valid[0][st] = 1'b0;
            m_valid[1][st] = 1'b0;
            m_lru[st]      = 1'b0;
        end
        @(posedge rstn);
        @(negedge clk);
        for (int i = 0; i < 1024; i++) begin
            exp_mem[i] = i_mem.words[i];
        end
        assert (ready && !mem_req && !rdata_valid && !op_ack)
            else fail_run("outputs not idle after reset");

        read_word(line_addr(1, 3), 1'b0); // miss then hit
        read_word(line_addr(1, 3), 1'b0);

        write_word(line_addr(1, 3), 32'h11223344, 4'b0101);
        read_word(line_addr(1, 3), 1'b0);
        write_word(line_addr(2, 5), 32'haabbccdd, 4'b1010); // write miss
        read_word(line_addr(2, 5), 1'b0);

        // replacement order A B A C then A and B again
        read_word(line_addr(1, 7), 1'b0);
        read_word(line_addr(2, 7), 1'b0);
        read_word(line_addr(1, 7), 1'b0);
        read_word(line_addr(3, 7), 1'b0);
        read_word(line_addr(1, 7), 1'b0);
        read_word(line_addr(2, 7), 1'b0);

        read_word(line_addr(4, 9), 1'b0);
        change_memory(line_addr(4, 9), 32'h5eedc0de);
        read_word(line_addr(4, 9), 1'b0); // old word from the cache
        read_word(line_addr(4, 9), 1'b1);
        read_word(line_addr(4, 9), 1'b0);

        read_word(line_addr(1, 11), 1'b0);
        read_word(line_addr(2, 11), 1'b0);
        run_cache_op(dcache_pkg::op_index_inv, line_addr(0, 11));
        read_word(line_addr(2, 11), 1'b0);
        read_word(line_addr(1, 11), 1'b0);
        run_cache_op(dcache_pkg::op_hit_inv, line_addr(2, 11));
        read_word(line_addr(1, 11), 1'b0);
        read_word(line_addr(2, 11), 1'b0);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== tb_mem.sv ====
`timescale 1ns/1ps

module tb_mem (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                mem_req,
    input  logic                                mem_wr,
    input  logic [dcache_pkg::addr_width-1:0]   mem_addr,
    input  logic [dcache_pkg::data_width-1:0]   mem_wdata,
    input  logic [dcache_pkg::data_width/8-1:0] mem_wstrb,
    output logic                                mem_addr_ok,
    output logic                                mem_data_ok,
    output logic [dcache_pkg::data_width-1:0]   mem_rdata,
    // direct update behind the cache
    input  logic                                poke_en,
    input  logic [dcache_pkg::addr_width-1:0]   poke_addr,
    input  logic [dcache_pkg::data_width-1:0]   poke_data
);

    localparam int words_n = 1024;

    logic [dcache_pkg::data_width-1:0]   words [words_n];
    logic [31:0]                         seed;
    logic [31:0]                         seed_next;
    logic [1:0]                          wait_q; // wait cycles left for this request
    logic                                done;
    int                                  rd_count;
    int                                  wr_count;
    logic [dcache_pkg::addr_width-1:0]   last_addr;
    logic [dcache_pkg::data_width-1:0]   last_wdata;
    logic [dcache_pkg::data_width/8-1:0] last_wstrb;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // pattern over the whole byte address
    function automatic logic [31:0] fill_word(input int i);
        return (32'(i) << 2) * 32'h9e3779b1 ^ 32'h3c3c5a5a;
    endfunction

    assign seed_next   = lcg_next(seed);
    assign done        = mem_req && (wait_q == 2'd0);
    assign mem_addr_ok = done && mem_wr;
    assign mem_data_ok = done && !mem_wr;
    assign mem_rdata   = words[mem_addr[11:2]];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            seed     <= 32'h0d7715f2;
            wait_q   <= 2'd0;
            rd_count <= 0;
            wr_count <= 0;
            for (int i = 0; i < words_n; i++) begin
                words[i] <= fill_word(i);
            end
        end else begin
            if (done) begin
                seed   <= seed_next;
                wait_q <= seed_next[31:30]; // 0 to 3 for the next request
            end else if (mem_req) begin
                wait_q <= wait_q - 2'd1;
            end
            if (mem_addr_ok) begin
                for (int b = 0; b < dcache_pkg::data_width / 8; b++) begin
                    if (mem_wstrb[b]) begin
                        words[mem_addr[11:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
                    end
                end
                wr_count   <= wr_count + 1;
                last_addr  <= mem_addr;
                last_wdata <= mem_wdata;
                last_wstrb <= mem_wstrb;
            end
            if (mem_data_ok) begin
                rd_count <= rd_count + 1;
            end
            if (poke_en) begin
                words[poke_addr[11:2]] <= poke_data;
            end
        end
    end

endmodule

// ==== verilog.f ====
dcache_pkg.sv
dcache_way.sv
dcache_lru.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock.sv
tb_mem.sv
tb_dcache.sv
